// File: flist.f
rtl/axi_mem_pkg.sv
rtl/mem_region_regs.sv
rtl/axi_read_channel.sv
rtl/axi_write_channel.sv
rtl/mem_bank.sv
rtl/axi_mem_slave.sv
verif/clock_gen.sv
verif/axi_mem_slave_tb.sv

// File: rtl/axi_mem_pkg.sv
package axi_mem_pkg;

  // bus widths
  localparam int AXI_ADDR_WIDTH = 32;
  localparam int AXI_DATA_WIDTH = 64;
  localparam int AXI_STRB_WIDTH = AXI_DATA_WIDTH / 8;

  // on-chip bank geometry, 2 KiB of 64-bit words
  localparam int MEM_DEPTH       = 256;
  localparam int MEM_INDEX_WIDTH = 8;

  // window compare starts right above the word index
  // word index is address bits 10..3
  localparam int WINDOW_LSB = 11;

  // window base out of reset
  localparam logic [AXI_ADDR_WIDTH-1:0] RESET_WINDOW_BASE = 32'h8000_0000;

  // AXI response codes
  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;
  localparam logic [1:0] RESP_DECERR = 2'b11;

  // configuration register select
  localparam logic CFG_SEL_BASE = 1'b0;
  localparam logic CFG_SEL_CTRL = 1'b1;

  // control register layout
  typedef struct packed {
    logic [30:0] reserved;
    logic        write_lock;
  } cfg_ctrl_t;

  // one config data word, two readings of it
  // base select uses the whole word as an address
  // ctrl select only looks at the lock bit
  typedef union packed {
    logic [AXI_ADDR_WIDTH-1:0] as_base;
    cfg_ctrl_t                 as_ctrl;
  } cfg_word_u;

endpackage

// File: rtl/axi_mem_slave.sv
`timescale 1ns/1ns

module axi_mem_slave
  import axi_mem_pkg::*;
(
  input  logic                      clock,
  input  logic                      reset_n,
  // AXI read address
  input  logic                      ar_valid_i,
  output logic                      ar_ready_o,
  input  logic [AXI_ADDR_WIDTH-1:0] ar_addr_i,
  // AXI read data
  output logic                      r_valid_o,
  input  logic                      r_ready_i,
  output logic [AXI_DATA_WIDTH-1:0] r_data_o,
  output logic [1:0]                r_resp_o,
  output logic                      r_last_o,
  // AXI write address
  input  logic                      aw_valid_i,
  output logic                      aw_ready_o,
  input  logic [AXI_ADDR_WIDTH-1:0] aw_addr_i,
  // AXI write data
  input  logic                      w_valid_i,
  output logic                      w_ready_o,
  input  logic [AXI_DATA_WIDTH-1:0] w_data_i,
  input  logic [AXI_STRB_WIDTH-1:0] w_strb_i,
  // AXI write response
  output logic                      b_valid_o,
  input  logic                      b_ready_i,
  output logic [1:0]                b_resp_o,
  // configuration strobe
  input  logic                      cfg_valid_i,
  input  logic                      cfg_sel_i,
  input  logic [AXI_ADDR_WIDTH-1:0] cfg_data_i
);

  // decode wires
  logic [AXI_ADDR_WIDTH-1:0]  rd_addr;
  logic [AXI_ADDR_WIDTH-1:0]  wr_addr;
  logic                       rd_hit;
  logic                       wr_hit;
  logic                       write_lock;

  // bank read side
  logic                       mem_re;
  logic [MEM_INDEX_WIDTH-1:0] mem_ridx;
  logic [AXI_DATA_WIDTH-1:0]  mem_rdata;

  // bank write side
  logic                       mem_we;
  logic [MEM_INDEX_WIDTH-1:0] mem_widx;
  logic [AXI_DATA_WIDTH-1:0]  mem_wdata;
  logic [AXI_STRB_WIDTH-1:0]  mem_wstrb;

  // window base and lock, shared by both channels
  mem_region_regs region_i (
    .clock        (clock),
    .reset_n      (reset_n),
    .cfg_valid_i  (cfg_valid_i),
    .cfg_sel_i    (cfg_sel_i),
    .cfg_data_i   (cfg_data_i),
    .rd_addr_i    (rd_addr),
    .wr_addr_i    (wr_addr),
    .rd_hit_o     (rd_hit),
    .wr_hit_o     (wr_hit),
    .write_lock_o (write_lock)
  );

  axi_read_channel rd_chan_i (
    .clock       (clock),
    .reset_n     (reset_n),
    .ar_valid_i  (ar_valid_i),
    .ar_ready_o  (ar_ready_o),
    .ar_addr_i   (ar_addr_i),
    .r_valid_o   (r_valid_o),
    .r_ready_i   (r_ready_i),
    .r_data_o    (r_data_o),
    .r_resp_o    (r_resp_o),
    .r_last_o    (r_last_o),
    .rd_addr_o   (rd_addr),
    .rd_hit_i    (rd_hit),
    .mem_re_o    (mem_re),
    .mem_ridx_o  (mem_ridx),
    .mem_rdata_i (mem_rdata)
  );

  axi_write_channel wr_chan_i (
    .clock        (clock),
    .reset_n      (reset_n),
    .aw_valid_i   (aw_valid_i),
    .aw_ready_o   (aw_ready_o),
    .aw_addr_i    (aw_addr_i),
    .w_valid_i    (w_valid_i),
    .w_ready_o    (w_ready_o),
    .w_data_i     (w_data_i),
    .w_strb_i     (w_strb_i),
    .b_valid_o    (b_valid_o),
    .b_ready_i    (b_ready_i),
    .b_resp_o     (b_resp_o),
    .wr_addr_o    (wr_addr),
    .wr_hit_i     (wr_hit),
    .write_lock_i (write_lock),
    .mem_we_o     (mem_we),
    .mem_widx_o   (mem_widx),
    .mem_wdata_o  (mem_wdata),
    .mem_wstrb_o  (mem_wstrb)
  );

  // single bank, one read and one write port
  mem_bank bank_i (
    .clock   (clock),
    .re_i    (mem_re),
    .ridx_i  (mem_ridx),
    .rdata_o (mem_rdata),
    .we_i    (mem_we),
    .widx_i  (mem_widx),
    .wdata_i (mem_wdata),
    .wstrb_i (mem_wstrb)
  );

endmodule

// File: rtl/axi_read_channel.sv
`timescale 1ns/1ns

module axi_read_channel
  import axi_mem_pkg::*;
(
  input  logic                       clock,
  input  logic                       reset_n,
  // AR channel
  input  logic                       ar_valid_i,
  output logic                       ar_ready_o,
  input  logic [AXI_ADDR_WIDTH-1:0]  ar_addr_i,
  // R channel
  output logic                       r_valid_o,
  input  logic                       r_ready_i,
  output logic [AXI_DATA_WIDTH-1:0]  r_data_o,
  output logic [1:0]                 r_resp_o,
  output logic                       r_last_o,
  // window decode
  output logic [AXI_ADDR_WIDTH-1:0]  rd_addr_o,
  input  logic                       rd_hit_i,
  // memory read port
  output logic                       mem_re_o,
  output logic [MEM_INDEX_WIDTH-1:0] mem_ridx_o,
  input  logic [AXI_DATA_WIDTH-1:0]  mem_rdata_i
);

  // fsm, low is idle and high is respond
  logic respond_q;
  // hit result captured with the AR handshake
  logic hit_q;

  logic ar_hs;
  logic r_hs;

  // accept a new address only when nothing is pending
  assign ar_ready_o = ~respond_q;
  assign r_valid_o  = respond_q;

  assign ar_hs = ar_valid_i & ar_ready_o;
  assign r_hs  = r_valid_o & r_ready_i;

  // address goes straight to the decoder
  assign rd_addr_o = ar_addr_i;

  // launch the bank read in the handshake cycle
  // data lands one edge later, together with r_valid
  assign mem_re_o   = ar_hs & rd_hit_i;
  assign mem_ridx_o = ar_addr_i[WINDOW_LSB-1:WINDOW_LSB-MEM_INDEX_WIDTH];

  always_ff @(posedge clock) begin
    if (!reset_n) begin
      respond_q <= 1'b0;
    end else if (ar_hs) begin
      respond_q <= 1'b1;
    end else if (r_hs) begin
      respond_q <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (ar_hs) begin
      hit_q <= rd_hit_i;
    end
  end

  // bank output only changes on a new read, so it holds
  // through any stall on r_ready
  assign r_data_o = hit_q ? mem_rdata_i : '0;
  assign r_resp_o = hit_q ? RESP_OKAY : RESP_DECERR;

  // single beat per transaction
  assign r_last_o = respond_q;

endmodule

// File: rtl/axi_write_channel.sv
`timescale 1ns/1ns

module axi_write_channel
  import axi_mem_pkg::*;
(
  input  logic                       clock,
  input  logic                       reset_n,
  // AW channel
  input  logic                       aw_valid_i,
  output logic                       aw_ready_o,
  input  logic [AXI_ADDR_WIDTH-1:0]  aw_addr_i,
  // W channel
  input  logic                       w_valid_i,
  output logic                       w_ready_o,
  input  logic [AXI_DATA_WIDTH-1:0]  w_data_i,
  input  logic [AXI_STRB_WIDTH-1:0]  w_strb_i,
  // B channel
  output logic                       b_valid_o,
  input  logic                       b_ready_i,
  output logic [1:0]                 b_resp_o,
  // window decode and lock
  output logic [AXI_ADDR_WIDTH-1:0]  wr_addr_o,
  input  logic                       wr_hit_i,
  input  logic                       write_lock_i,
  // memory write port
  output logic                       mem_we_o,
  output logic [MEM_INDEX_WIDTH-1:0] mem_widx_o,
  output logic [AXI_DATA_WIDTH-1:0]  mem_wdata_o,
  output logic [AXI_STRB_WIDTH-1:0]  mem_wstrb_o
);

  // holding flags, one per channel
  logic aw_held_q;
  logic w_held_q;
  logic b_valid_q;
  logic [1:0] b_resp_q;

  // captured address info
  logic                       wr_hit_q;
  logic [MEM_INDEX_WIDTH-1:0] widx_q;
  // captured data beat
  logic [AXI_DATA_WIDTH-1:0]  wdata_q;
  logic [AXI_STRB_WIDTH-1:0]  wstrb_q;

  logic aw_hs;
  logic w_hs;
  logic b_hs;
  logic issue;
  logic [1:0] resp_d;

  // each ready drops once its own beat is held
  assign aw_ready_o = ~aw_held_q;
  assign w_ready_o  = ~w_held_q;

  assign aw_hs = aw_valid_i & aw_ready_o;
  assign w_hs  = w_valid_i & w_ready_o;
  assign b_hs  = b_valid_q & b_ready_i;

  assign wr_addr_o = aw_addr_i;

  // both halves present and no response out yet
  assign issue = aw_held_q & w_held_q & ~b_valid_q;

  // miss wins over lock
  always_comb begin
    if (!wr_hit_q) begin
      resp_d = RESP_DECERR;
    end else if (write_lock_i) begin
      resp_d = RESP_SLVERR;
    end else begin
      resp_d = RESP_OKAY;
    end
  end

  // write and b_valid land on the same edge
  assign mem_we_o    = issue & (resp_d == RESP_OKAY);
  assign mem_widx_o  = widx_q;
  assign mem_wdata_o = wdata_q;
  assign mem_wstrb_o = wstrb_q;

  always_ff @(posedge clock) begin
    if (!reset_n) begin
      aw_held_q <= 1'b0;
      w_held_q  <= 1'b0;
      b_valid_q <= 1'b0;
    end else if (b_hs) begin
      // readies come back the cycle after B
      aw_held_q <= 1'b0;
      w_held_q  <= 1'b0;
      b_valid_q <= 1'b0;
    end else begin
      if (aw_hs) begin
        aw_held_q <= 1'b1;
      end
      if (w_hs) begin
        w_held_q <= 1'b1;
      end
      if (issue) begin
        b_valid_q <= 1'b1;
      end
    end
  end

  // address side capture, hit taken at handshake
  always_ff @(posedge clock) begin
    if (aw_hs) begin
      wr_hit_q <= wr_hit_i;
      widx_q   <= aw_addr_i[WINDOW_LSB-1:WINDOW_LSB-MEM_INDEX_WIDTH];
    end
  end

  // data side capture
  always_ff @(posedge clock) begin
    if (w_hs) begin
      wdata_q <= w_data_i;
      wstrb_q <= w_strb_i;
    end
  end

  // response frozen until accepted
  always_ff @(posedge clock) begin
    if (issue) begin
      b_resp_q <= resp_d;
    end
  end

  assign b_valid_o = b_valid_q;
  assign b_resp_o  = b_resp_q;

endmodule

// File: rtl/mem_bank.sv
`timescale 1ns/1ns

module mem_bank
  import axi_mem_pkg::*;
(
  input  logic                       clock,
  // read port
  input  logic                       re_i,
  input  logic [MEM_INDEX_WIDTH-1:0] ridx_i,
  output logic [AXI_DATA_WIDTH-1:0]  rdata_o,
  // byte-strobed write port
  input  logic                       we_i,
  input  logic [MEM_INDEX_WIDTH-1:0] widx_i,
  input  logic [AXI_DATA_WIDTH-1:0]  wdata_i,
  input  logic [AXI_STRB_WIDTH-1:0]  wstrb_i
);

  // word array, contents not reset
  logic [AXI_DATA_WIDTH-1:0] mem_q [MEM_DEPTH];

  // registered read
  // holds its value while re_i is low
  // same-edge write to the same word is not seen, old data returned
  always_ff @(posedge clock) begin
    if (re_i) begin
      rdata_o <= mem_q[ridx_i];
    end
  end

  // per byte lane update
  always_ff @(posedge clock) begin
    if (we_i) begin
      for (int b = 0; b < AXI_STRB_WIDTH; b++) begin
        if (wstrb_i[b]) begin
          mem_q[widx_i][b*8 +: 8] <= wdata_i[b*8 +: 8];
        end
      end
    end
  end

endmodule

// File: rtl/mem_region_regs.sv
`timescale 1ns/1ns

module mem_region_regs
  import axi_mem_pkg::*;
(
  input  logic                      clock,
  input  logic                      reset_n,
  // config strobe, no back-pressure
  input  logic                      cfg_valid_i,
  input  logic                      cfg_sel_i,
  input  logic [AXI_ADDR_WIDTH-1:0] cfg_data_i,
  // addresses presented by the two channels
  input  logic [AXI_ADDR_WIDTH-1:0] rd_addr_i,
  input  logic [AXI_ADDR_WIDTH-1:0] wr_addr_i,
  output logic                      rd_hit_o,
  output logic                      wr_hit_o,
  output logic                      write_lock_o
);

  // only the compared bits of the base are kept
  logic [AXI_ADDR_WIDTH-1:WINDOW_LSB] base_q;
  logic                               write_lock_q;

  // incoming word, decoded per select
  cfg_word_u cfg_word;

  assign cfg_word = cfg_word_u'(cfg_data_i);

  // base register
  always_ff @(posedge clock) begin
    if (!reset_n) begin
      base_q <= RESET_WINDOW_BASE[AXI_ADDR_WIDTH-1:WINDOW_LSB];
    end else if (cfg_valid_i && (cfg_sel_i == CFG_SEL_BASE)) begin
      // low bits of the base are ignored
      base_q <= cfg_word.as_base[AXI_ADDR_WIDTH-1:WINDOW_LSB];
    end
  end

  // control register, only the lock bit is live
  always_ff @(posedge clock) begin
    if (!reset_n) begin
      write_lock_q <= 1'b0;
    end else if (cfg_valid_i && (cfg_sel_i == CFG_SEL_CTRL)) begin
      write_lock_q <= cfg_word.as_ctrl.write_lock;
    end
  end

  // window hit for each channel
  // new base is seen from the cycle after the strobe
  always_comb begin
    rd_hit_o = (rd_addr_i[AXI_ADDR_WIDTH-1:WINDOW_LSB] == base_q);
    wr_hit_o = (wr_addr_i[AXI_ADDR_WIDTH-1:WINDOW_LSB] == base_q);
  end

  assign write_lock_o = write_lock_q;

endmodule

// File: verif/axi_mem_slave_tb.sv
`timescale 1ns/1ns

module axi_mem_slave_tb
  import axi_mem_pkg::*;
();

  // ~100 transactions, worst case handshakes plus 7 stall cycles each
  localparam int TXN_COUNT      = 100;
  localparam int CYCLES_PER_TXN = 16;
  localparam int CYCLE_LIMIT    = TXN_COUNT * CYCLES_PER_TXN + 4 + 16;

  logic clock;
  logic reset_n;
  logic ar_valid_i, ar_ready_o, r_valid_o, r_ready_i, r_last_o;
  logic aw_valid_i, aw_ready_o, w_valid_i, w_ready_o, b_valid_o, b_ready_i;
  logic cfg_valid_i, cfg_sel_i;
  logic [AXI_ADDR_WIDTH-1:0] ar_addr_i, aw_addr_i, cfg_data_i;
  logic [AXI_DATA_WIDTH-1:0] r_data_o, w_data_i;
  logic [AXI_STRB_WIDTH-1:0] w_strb_i;
  logic [1:0]                r_resp_o, b_resp_o;

  // reference model of memory, window and lock
  logic [AXI_DATA_WIDTH-1:0] model_mem [MEM_DEPTH];
  logic [AXI_ADDR_WIDTH-1:0] win_base = RESET_WINDOW_BASE;
  logic                      win_lock = 1'b0;
  // expected responses of the transaction in flight
  logic [AXI_DATA_WIDTH-1:0] exp_rdata;
  logic [1:0]                exp_rresp, exp_bresp;

  logic [31:0] seed = 32'hbf8e_2f8c;
  string       cur_test = "reset";
  int          errors = 0;
  int          start_errors = 0;
  int          tests_run = 0;
  int          tests_failed = 0;
  int          max_stall = 1;
  int          cycles = 0;
  logic        req_seen = 1'b0;
  // write handshake monitor
  logic        aw_seen, w_seen, aw_hs, w_hs, last_hs;
  // later handshake edge, delayed by one
  logic        last_hs_q;
  // read pending between AR and R handshakes
  logic        rd_seen;

  clock_gen clock_gen_i (.clock_o(clock), .reset_n_o(reset_n));

  axi_mem_slave dut_i (.*);

  assign aw_hs = aw_valid_i & aw_ready_o;
  assign w_hs  = w_valid_i & w_ready_o;
  // the later of AW and W completes on this edge
  assign last_hs = (aw_hs | w_hs) & (aw_seen | aw_hs) & (w_seen | w_hs);

  always @(posedge clock) begin
    if (!reset_n || (b_valid_o && b_ready_i)) begin
      aw_seen <= 1'b0;
      w_seen  <= 1'b0;
    end else begin
      aw_seen <= aw_seen | aw_hs;
      w_seen  <= w_seen | w_hs;
    end
  end

  // b_valid is set on the edge after the later handshake
  always @(posedge clock) begin
    last_hs_q <= last_hs;
    if (!reset_n || (r_valid_o && r_ready_i)) begin
      rd_seen <= 1'b0;
    end else if (ar_valid_i && ar_ready_o) begin
      rd_seen <= 1'b1;
    end
  end

  // run limit
  always @(posedge clock) begin
    cycles <= cycles + 1;
    if (cycles == CYCLE_LIMIT) begin
      $display("timeout: run did not end within %0d cycles", CYCLE_LIMIT);
      $display("Test FAILED");
      $finish;
    end
  end

  task automatic report_error(input string msg);
    $display("%s", msg);
    errors++;
  endtask

  a_idle: assert property (@(posedge clock) disable iff (!reset_n)
      !req_seen |-> !r_valid_o && !b_valid_o)
    else report_error("r_valid or b_valid went high before any request");
  a_ready: assert property (@(posedge clock) disable iff (!reset_n)
      ar_ready_o == !rd_seen && aw_ready_o == !aw_seen && w_ready_o == !w_seen)
    else report_error($sformatf("a ready was out of step with the handshakes in %s",
      cur_test));
  a_r_rise: assert property (@(posedge clock) disable iff (!reset_n)
      ar_valid_i && ar_ready_o |=> $rose(r_valid_o))
    else report_error($sformatf("r_valid did not rise one cycle after AR in %s", cur_test));
  a_r_last: assert property (@(posedge clock) disable iff (!reset_n) r_valid_o |-> r_last_o)
    else report_error($sformatf("r_last low while r_valid high in %s", cur_test));
  a_r_data: assert property (@(posedge clock) disable iff (!reset_n)
      r_valid_o && r_ready_i |-> r_data_o == exp_rdata && r_resp_o == exp_rresp)
    else report_error($sformatf("FAILED %s: expected %h/%b, actual %h/%b", cur_test,
      $sampled(exp_rdata), $sampled(exp_rresp), $sampled(r_data_o), $sampled(r_resp_o)));
  a_r_hold: assert property (@(posedge clock) disable iff (!reset_n)
      r_valid_o && !r_ready_i |=> r_valid_o && $stable(r_data_o) && $stable(r_resp_o))
    else report_error($sformatf("R channel changed while stalled in %s", cur_test));
  a_b_rise: assert property (@(posedge clock) disable iff (!reset_n)
      last_hs_q |=> $rose(b_valid_o))
    else report_error($sformatf("b_valid not one cycle after AW/W in %s", cur_test));
  a_b_resp: assert property (@(posedge clock) disable iff (!reset_n)
      b_valid_o && b_ready_i |-> b_resp_o == exp_bresp)
    else report_error($sformatf("FAILED %s: expected b_resp %b, actual %b", cur_test,
      $sampled(exp_bresp), $sampled(b_resp_o)));
  a_b_hold: assert property (@(posedge clock) disable iff (!reset_n)
      b_valid_o && !b_ready_i |=> b_valid_o && $stable(b_resp_o))
    else report_error($sformatf("B channel changed while stalled in %s", cur_test));

  // lcg, numerical recipes constants
  function automatic logic [31:0] next_rand();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  function automatic logic hits(input logic [31:0] addr);
    return addr[31:WINDOW_LSB] == win_base[31:WINDOW_LSB];
  endfunction

  // random word address in the current window
  function automatic logic [31:0] window_addr();
    logic [31:0] r;
    r = next_rand();
    return {win_base[31:WINDOW_LSB], r[15:8], 3'b000};
  endfunction

  // wait until every driven valid has been taken
  task automatic wait_accept();
    @(posedge clock);
    while ((aw_valid_i && !aw_ready_o) || (w_valid_i && !w_ready_o) ||
           (ar_valid_i && !ar_ready_o)) @(posedge clock);
  endtask

  // hold ready low a random while, then take R or B
  task automatic accept_response(input logic is_read);
    int n;
    @(posedge clock);
    while (!(is_read ? r_valid_o : b_valid_o)) @(posedge clock);
    n = int'(next_rand() >> 16) % (max_stall + 1);
    repeat (n) @(posedge clock);
    r_ready_i <= is_read;
    b_ready_i <= !is_read;
    @(posedge clock);
    r_ready_i <= 1'b0;
    b_ready_i <= 1'b0;
  endtask

  task automatic read_txn(input logic [31:0] addr);
    exp_rdata  = hits(addr) ? model_mem[addr[10:3]] : '0;
    exp_rresp  = hits(addr) ? RESP_OKAY : RESP_DECERR;
    req_seen   = 1'b1;
    ar_valid_i <= 1'b1;
    ar_addr_i  <= addr;
    wait_accept();
    ar_valid_i <= 1'b0;
    accept_response(1'b1);
  endtask

  // order 0 is AW first, 1 is W first, 2 is both on one edge
  task automatic write_txn(input logic [31:0] addr, input logic [63:0] data,
                           input logic [7:0] strb, input int order);
    exp_bresp = !hits(addr) ? RESP_DECERR : (win_lock ? RESP_SLVERR : RESP_OKAY);
    req_seen  = 1'b1;
    aw_addr_i <= addr;
    w_data_i  <= data;
    w_strb_i  <= strb;
    aw_valid_i <= (order != 1);
    w_valid_i  <= (order != 0);
    wait_accept();
    aw_valid_i <= (order == 1);
    w_valid_i  <= (order == 0);
    if (order != 2) begin
      wait_accept();
      aw_valid_i <= 1'b0;
      w_valid_i  <= 1'b0;
    end
    if (exp_bresp == RESP_OKAY) begin
      for (int b = 0; b < AXI_STRB_WIDTH; b++) begin
        if (strb[b]) model_mem[addr[10:3]][b*8 +: 8] = data[b*8 +: 8];
      end
    end
    accept_response(1'b0);
  endtask

  task automatic set_cfg(input logic sel, input logic [31:0] data);
    cfg_valid_i <= 1'b1;
    cfg_sel_i   <= sel;
    cfg_data_i  <= data;
    @(posedge clock);
    cfg_valid_i <= 1'b0;
    if (sel == CFG_SEL_BASE) begin
      win_base = data;
    end else begin
      win_lock = data[0];
    end
  endtask

  task automatic begin_test(input string name);
    cur_test     = name;
    start_errors = errors;
  endtask

  task automatic end_test();
    tests_run++;
    if (errors != start_errors) begin
      tests_failed++;
      $display("test %s failed with %0d errors", cur_test, errors - start_errors);
    end else begin
      $display("test %s passed", cur_test);
    end
  endtask

  initial begin
    logic [31:0] addrs [16];
    logic [31:0] a;
    logic [31:0] r;
    {ar_valid_i, r_ready_i, aw_valid_i, w_valid_i, b_ready_i} = '0;
    {cfg_valid_i, cfg_sel_i, cfg_data_i, ar_addr_i, aw_addr_i} = '0;
    w_data_i = '0;
    w_strb_i = '0;
    wait (reset_n);
    @(posedge clock);

    // outputs stay quiet with no request
    begin_test("reset_idle");
    repeat (6) @(posedge clock);
    end_test();

    begin_test("read_back");
    for (int i = 0; i < 16; i++) begin
      addrs[i] = window_addr();
      write_txn(addrs[i], {next_rand(), next_rand()}, 8'hff, i % 3);
    end
    for (int i = 0; i < 16; i++) read_txn(addrs[i]);
    // partial strobes over words already written
    for (int i = 0; i < 8; i++) begin
      r = next_rand();
      write_txn(addrs[i], {next_rand(), next_rand()}, r[23:16], 2);
      read_txn(addrs[i]);
    end
    end_test();

    begin_test("write_order");
    for (int order = 0; order < 3; order++) begin
      write_txn(addrs[order], {next_rand(), next_rand()}, 8'hff, order);
      read_txn(addrs[order]);
    end
    end_test();

    begin_test("back_pressure");
    max_stall = 7;
    for (int i = 0; i < 12; i++) begin
      write_txn(addrs[i], {next_rand(), next_rand()}, 8'hff, i % 3);
      read_txn(addrs[i]);
    end
    max_stall = 1;
    end_test();

    begin_test("window");
    // bit 11 flipped, same word index
    a = addrs[0] ^ 32'h0000_0800;
    read_txn(a);
    write_txn(a, {next_rand(), next_rand()}, 8'hff, 2);
    read_txn(addrs[0]);
    set_cfg(CFG_SEL_BASE, 32'h4000_0000);
    read_txn(addrs[0]);
    a = 32'h4000_0000 | addrs[0][10:0];
    write_txn(a, {next_rand(), next_rand()}, 8'hff, 0);
    read_txn(a);
    set_cfg(CFG_SEL_BASE, RESET_WINDOW_BASE);
    read_txn(addrs[0]);
    end_test();

    begin_test("write_lock");
    set_cfg(CFG_SEL_CTRL, 32'h1);
    write_txn(addrs[1], {next_rand(), next_rand()}, 8'hff, 1);
    read_txn(addrs[1]);
    set_cfg(CFG_SEL_CTRL, 32'h0);
    write_txn(addrs[1], {next_rand(), next_rand()}, 8'hff, 0);
    read_txn(addrs[1]);
    end_test();

    repeat (2) @(posedge clock);
    $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

// File: verif/clock_gen.sv
`timescale 1ns/1ns

module clock_gen (
  output logic clock_o,
  output logic reset_n_o
);

  // 8 ns period
  initial begin
    clock_o = 1'b0;
    forever #4 clock_o = ~clock_o;
  end

  // reset low over the first 4 rising edges
  initial begin
    reset_n_o = 1'b0;
    repeat (4) @(posedge clock_o);
    reset_n_o <= 1'b1;
  end

endmodule
